// File: stage_consts.svh
`ifndef STAGE_CONSTS_SVH
`define STAGE_CONSTS_SVH

// datapath and address widths
`define DATA_W 64
`define ADDR_W 32

// words per read burst
`define BURST_BEATS 8

// word counters, byte count / 8
`define CNT_W 25

// register map
`define REG_IDX_W 2
`define REG_SRC 2'd0
`define REG_DEST 2'd1
`define REG_LEN 2'd2
`define REG_CMD 2'd3

`endif

// File: stagePkg.sv
`default_nettype none
`include "stage_consts.svh"

package stagePkg;

  // one host register write, always accepted
  typedef struct packed {
    logic valid;
    logic [`REG_IDX_W-1:0] idx;
    logic [31:0] value;
  } regWriteT;

  // length register layout
  typedef struct packed {
    logic [3:0] shift;
    logic [27:0] byteCount;
  } lenWordT;

  // job as seen by reader and writer
  typedef struct packed {
    logic [`ADDR_W-1:0] src;
    logic [`ADDR_W-1:0] dest;
    logic [`CNT_W-1:0] inWords;
    logic [`CNT_W-1:0] outWords;
    logic [3:0] shift;
  } jobDescT;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
  } rdReqT;

  // last marks the final beat of a burst
  typedef struct packed {
    logic [`DATA_W-1:0] data;
    logic last;
  } rdRespT;

  typedef struct packed {
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] data;
  } wrReqT;

endpackage

`default_nettype wire

// File: dmaControl.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module dmaControl (
  input  logic FCLK0,
  input  logic rstN,
  input  stagePkg::regWriteT regWrite,
  input  logic readerDone,
  input  logic writerDone,
  output stagePkg::jobDescT job,
  output logic start,
  output logic busy,
  output logic irq
);

  import stagePkg::*;

  logic [`ADDR_W-1:0] srcReg;
  logic [`ADDR_W-1:0] destReg;
  lenWordT lenReg;
  logic [`CNT_W-1:0] inWords;
  logic launch;
  logic readerSeen;
  logic writerSeen;
  logic readerFin;
  logic writerFin;

  // byte count in 64-bit words
  assign inWords = lenReg.byteCount[27:3];

  // start bit of a command write, dropped while a job runs
  assign launch = regWrite.valid && (regWrite.idx == `REG_CMD) && regWrite.value[0] && !busy;

  assign readerFin = readerSeen || readerDone;
  assign writerFin = writerSeen || writerDone;

  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      srcReg <= '0;
      destReg <= '0;
      lenReg <= '0;
    end else if (regWrite.valid) begin
      case (regWrite.idx)
        `REG_SRC: srcReg <= regWrite.value;
        `REG_DEST: destReg <= regWrite.value;
        `REG_LEN: lenReg <= regWrite.value;
        default: ;
      endcase
    end
  end

  // job snapshot taken together with start
  always_ff @(posedge FCLK0) begin
    if (launch) begin
      job.src <= srcReg;
      job.dest <= destReg;
      job.inWords <= inWords;
      job.outWords <= inWords >> lenReg.shift;
      job.shift <= lenReg.shift;
    end
  end

  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      start <= 1'b0;
      busy <= 1'b0;
      irq <= 1'b0;
      readerSeen <= 1'b0;
      writerSeen <= 1'b0;
    end else begin
      start <= launch;
      irq <= 1'b0;
      if (launch) begin
        busy <= 1'b1;
        readerSeen <= 1'b0;
        writerSeen <= 1'b0;
      end else if (busy) begin
        if (readerDone) readerSeen <= 1'b1;
        if (writerDone) writerSeen <= 1'b1;
        // both sides finished in either order
        if (readerFin && writerFin) begin
          busy <= 1'b0;
          irq <= 1'b1;
        end
      end
    end
  end

  doneOnlyWhileBusy: assert property (@(posedge FCLK0) disable iff (!rstN)
    (readerDone || writerDone) |-> busy);

endmodule

`default_nettype wire

// File: burstReader.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module burstReader (
  input  logic FCLK0,
  input  logic rstN,
  input  stagePkg::jobDescT job,
  input  logic start,
  output stagePkg::rdReqT rdReq,
  output logic rdReqValid,
  input  logic rdReqReady,
  input  stagePkg::rdRespT rdResp,
  input  logic rdRespValid,
  output logic rdRespReady,
  output logic [`DATA_W-1:0] rdData,
  output logic rdValid,
  input  logic rdReady,
  output logic done
);

  logic [`ADDR_W-1:0] addr;
  logic [`CNT_W-1:0] reqLeft;
  logic [`CNT_W-1:0] rcvLeft;
  logic outstanding;
  logic reqFire;
  logic respFire;

  // response words go straight downstream
  assign rdData = rdResp.data;
  assign rdValid = rdRespValid;
  assign rdRespReady = rdReady;

  assign reqFire = rdReqValid && rdReqReady;
  assign respFire = rdRespValid && rdRespReady;

  // next burst address
  always_ff @(posedge FCLK0) begin
    if (start) begin
      addr <= job.src;
    end else if (reqFire) begin
      addr <= addr + `ADDR_W'(`BURST_BEATS * (`DATA_W / 8));
    end
  end

  always_ff @(posedge FCLK0) begin
    if (!rdReqValid) begin
      rdReq.addr <= addr;
    end
  end

  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      reqLeft <= '0;
      rcvLeft <= '0;
      rdReqValid <= 1'b0;
      outstanding <= 1'b0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        reqLeft <= job.inWords;
        rcvLeft <= job.inWords;
      end else begin
        // one burst in flight at a time
        if (!rdReqValid && !outstanding && reqLeft != '0) begin
          rdReqValid <= 1'b1;
        end else if (reqFire) begin
          rdReqValid <= 1'b0;
          outstanding <= 1'b1;
          reqLeft <= reqLeft - `CNT_W'(`BURST_BEATS);
        end
        if (respFire) begin
          rcvLeft <= rcvLeft - 1'b1;
          if (rdResp.last) outstanding <= 1'b0;
          if (rcvLeft == `CNT_W'(1)) done <= 1'b1;
        end
      end
    end
  end

  respWithoutBurst: assert property (@(posedge FCLK0) disable iff (!rstN)
    rdRespValid |-> outstanding);

endmodule

`default_nettype wire

// File: wordDecimator.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module wordDecimator (
  input  logic FCLK0,
  input  logic rstN,
  input  logic start,
  input  logic [3:0] shift,
  input  logic [`DATA_W-1:0] inData,
  input  logic inValid,
  output logic inReady,
  output logic [`DATA_W-1:0] outData,
  output logic outValid,
  input  logic outReady
);

  localparam int PHASE_W = 15;

  logic [PHASE_W-1:0] phase;
  logic [PHASE_W-1:0] phaseMask;
  logic keep;
  logic inFire;

  // 2^shift - 1, all ones for shift 15
  assign phaseMask = (PHASE_W'(1) << shift) - PHASE_W'(1);
  assign keep = (phase & phaseMask) == '0;

  // empty, or draining this cycle
  assign inReady = !outValid || outReady;
  assign inFire = inValid && inReady;

  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      phase <= '0;
      outValid <= 1'b0;
    end else begin
      if (start) begin
        phase <= '0;
      end else if (inFire) begin
        phase <= phase + 1'b1;
      end
      if (inFire && keep) begin
        outValid <= 1'b1;
      end else if (outReady) begin
        outValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge FCLK0) begin
    if (inFire && keep) begin
      outData <= inData;
    end
  end

endmodule

`default_nettype wire

// File: burstWriter.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module burstWriter (
  input  logic FCLK0,
  input  logic rstN,
  input  stagePkg::jobDescT job,
  input  logic start,
  input  logic [`DATA_W-1:0] inData,
  input  logic inValid,
  output logic inReady,
  output stagePkg::wrReqT wrReq,
  output logic wrReqValid,
  input  logic wrReqReady,
  input  logic wrAckValid,
  output logic done
);

  logic [`ADDR_W-1:0] addr;
  logic [`CNT_W-1:0] ackLeft;
  logic [`CNT_W-1:0] pending;
  logic inFire;
  logic wrFire;

  assign inReady = !wrReqValid || wrReqReady;
  assign inFire = inValid && inReady;
  assign wrFire = wrReqValid && wrReqReady;

  // destination walks one word per write
  always_ff @(posedge FCLK0) begin
    if (start) begin
      addr <= job.dest;
    end else if (inFire) begin
      addr <= addr + `ADDR_W'(`DATA_W / 8);
    end
  end

  always_ff @(posedge FCLK0) begin
    if (inFire) begin
      wrReq.addr <= addr;
      wrReq.data <= inData;
    end
  end

  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      wrReqValid <= 1'b0;
    end else if (inFire) begin
      wrReqValid <= 1'b1;
    end else if (wrReqReady) begin
      wrReqValid <= 1'b0;
    end
  end

  // writes accepted by memory but not yet acknowledged
  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      pending <= '0;
    end else begin
      case ({wrFire, wrAckValid})
        2'b10: pending <= pending + 1'b1;
        2'b01: pending <= pending - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      ackLeft <= '0;
      done <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        ackLeft <= job.outWords;
      end else if (wrAckValid) begin
        ackLeft <= ackLeft - 1'b1;
        if (ackLeft == `CNT_W'(1)) done <= 1'b1;
      end
    end
  end

  ackWithoutWrite: assert property (@(posedge FCLK0) disable iff (!rstN)
    wrAckValid |-> pending != '0);

endmodule

`default_nettype wire

// File: streamStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module streamStage (
  input  logic FCLK0,
  input  logic rstN,
  input  stagePkg::regWriteT regWrite,
  output stagePkg::rdReqT rdReq,
  output logic rdReqValid,
  input  logic rdReqReady,
  input  stagePkg::rdRespT rdResp,
  input  logic rdRespValid,
  output logic rdRespReady,
  output stagePkg::wrReqT wrReq,
  output logic wrReqValid,
  input  logic wrReqReady,
  input  logic wrAckValid,
  output logic busy,
  output logic irq
);

  import stagePkg::*;

  jobDescT job;
  logic start;
  logic readerDone;
  logic writerDone;

  // reader to decimator
  logic [`DATA_W-1:0] rdData;
  logic rdValid;
  logic rdReady;

  // decimator to writer
  logic [`DATA_W-1:0] decData;
  logic decValid;
  logic decReady;

  dmaControl u_dmaControl (
    .FCLK0(FCLK0),
    .rstN(rstN),
    .regWrite(regWrite),
    .readerDone(readerDone),
    .writerDone(writerDone),
    .job(job),
    .start(start),
    .busy(busy),
    .irq(irq)
  );

  burstReader u_burstReader (
    .FCLK0(FCLK0),
    .rstN(rstN),
    .job(job),
    .start(start),
    .rdReq(rdReq),
    .rdReqValid(rdReqValid),
    .rdReqReady(rdReqReady),
    .rdResp(rdResp),
    .rdRespValid(rdRespValid),
    .rdRespReady(rdRespReady),
    .rdData(rdData),
    .rdValid(rdValid),
    .rdReady(rdReady),
    .done(readerDone)
  );

  wordDecimator u_wordDecimator (
    .FCLK0(FCLK0),
    .rstN(rstN),
    .start(start),
    .shift(job.shift),
    .inData(rdData),
    .inValid(rdValid),
    .inReady(rdReady),
    .outData(decData),
    .outValid(decValid),
    .outReady(decReady)
  );

  burstWriter u_burstWriter (
    .FCLK0(FCLK0),
    .rstN(rstN),
    .job(job),
    .start(start),
    .inData(decData),
    .inValid(decValid),
    .inReady(decReady),
    .wrReq(wrReq),
    .wrReqValid(wrReqValid),
    .wrReqReady(wrReqReady),
    .wrAckValid(wrAckValid),
    .done(writerDone)
  );

endmodule

`default_nettype wire

// File: tbMemoryModel.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module tbMemoryModel (
  input  logic FCLK0,
  input  logic rstN,
  input  logic [6:0] reqStall,
  input  logic [6:0] respStall,
  input  logic [6:0] wrStall,
  input  stagePkg::rdReqT rdReq,
  input  logic rdReqValid,
  output logic rdReqReady,
  output stagePkg::rdRespT rdResp,
  output logic rdRespValid,
  input  logic rdRespReady,
  input  stagePkg::wrReqT wrReq,
  input  logic wrReqValid,
  output logic wrReqReady,
  output logic wrAckValid
);

  import stagePkg::*;

  localparam int WORDS = 1024;

  logic [`DATA_W-1:0] mem [0:WORDS-1];
  logic [`ADDR_W-1:0] rdAddr;
  int beatsLeft;
  logic respTaken;
  logic ackDue;

  // stall chance given in percent
  function automatic logic stallNow(input logic [6:0] pct);
    return $urandom_range(99, 0) < {25'd0, pct};
  endfunction

  // handshakes are seen on the rising edge
  always @(posedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      rdAddr <= '0;
      beatsLeft <= 0;
      respTaken <= 1'b0;
      ackDue <= 1'b0;
    end else begin
      respTaken <= rdRespValid && rdRespReady;
      ackDue <= wrReqValid && wrReqReady;
      if (rdReqValid && rdReqReady) begin
        rdAddr <= rdReq.addr;
        beatsLeft <= `BURST_BEATS;
      end else if (rdRespValid && rdRespReady) begin
        rdAddr <= rdAddr + `ADDR_W'(8);
        beatsLeft <= beatsLeft - 1;
      end
    end
  end

  always @(posedge FCLK0) begin
    if (rstN && wrReqValid && wrReqReady) begin
      mem[wrReq.addr[12:3]] = wrReq.data;
    end
  end

  // outputs change on the falling edge only
  always @(negedge FCLK0 or negedge rstN) begin
    if (!rstN) begin
      rdReqReady <= 1'b0;
      rdRespValid <= 1'b0;
      rdResp <= '0;
      wrReqReady <= 1'b0;
      wrAckValid <= 1'b0;
    end else begin
      rdReqReady <= !stallNow(reqStall);
      wrReqReady <= !stallNow(wrStall);
      wrAckValid <= ackDue;
      if (rdRespValid && !respTaken) begin
        // response held until taken
        rdRespValid <= 1'b1;
      end else if (beatsLeft > 0 && !stallNow(respStall)) begin
        rdRespValid <= 1'b1;
        rdResp.data <= mem[rdAddr[12:3]];
        rdResp.last <= beatsLeft == 1;
      end else begin
        rdRespValid <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: tbStage.sv
`timescale 1ns/100ps
`default_nettype none
`include "stage_consts.svh"

module tbStage;

  import stagePkg::*;

  localparam int CYCLE_NS = 40;
  localparam int MEM_WORDS = 1024;
  // input words of every job in the run
  localparam int TOTAL_WORDS = 32 + 64 + 64 + 64 + 32 + 32 + 64 + 64;

  logic FCLK0;
  logic rstN;
  regWriteT regWrite;
  rdReqT rdReq;
  logic rdReqValid;
  logic rdReqReady;
  rdRespT rdResp;
  logic rdRespValid;
  logic rdRespReady;
  wrReqT wrReq;
  logic wrReqValid;
  logic wrReqReady;
  logic wrAckValid;
  logic busy;
  logic irq;
  logic [6:0] reqStall;
  logic [6:0] respStall;
  logic [6:0] wrStall;

  logic [`DATA_W-1:0] expMem [0:MEM_WORDS-1];
  int irqCount = 0;
  logic busyLast = 1'b0;

  streamStage u_streamStage (
    .FCLK0(FCLK0),
    .rstN(rstN),
    .regWrite(regWrite),
    .rdReq(rdReq),
    .rdReqValid(rdReqValid),
    .rdReqReady(rdReqReady),
    .rdResp(rdResp),
    .rdRespValid(rdRespValid),
    .rdRespReady(rdRespReady),
    .wrReq(wrReq),
    .wrReqValid(wrReqValid),
    .wrReqReady(wrReqReady),
    .wrAckValid(wrAckValid),
    .busy(busy),
    .irq(irq)
  );

  tbMemoryModel u_memory (
    .FCLK0(FCLK0),
    .rstN(rstN),
    .reqStall(reqStall),
    .respStall(respStall),
    .wrStall(wrStall),
    .rdReq(rdReq),
    .rdReqValid(rdReqValid),
    .rdReqReady(rdReqReady),
    .rdResp(rdResp),
    .rdRespValid(rdRespValid),
    .rdRespReady(rdRespReady),
    .wrReq(wrReq),
    .wrReqValid(wrReqValid),
    .wrReqReady(wrReqReady),
    .wrAckValid(wrAckValid)
  );

  initial FCLK0 = 1'b0;
  always #(CYCLE_NS / 2) FCLK0 = ~FCLK0;

  task automatic checkWord(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
                           input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic checkBit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // every irq must coincide with busy falling
  always @(negedge FCLK0) begin
    if (rstN) begin
      if (irq) begin
        irqCount = irqCount + 1;
        checkBit(busy, 1'b0, "busy in irq cycle");
        checkBit(busyLast, 1'b1, "busy before irq");
      end else if (busyLast) begin
        checkBit(busy, 1'b1, "busy without irq");
      end
    end
    busyLast = busy;
  end

  initial begin
    #(TOTAL_WORDS * 200 * CYCLE_NS);
    $display("watchdog expired at %0t, a job never finished", $time);
    $display("TEST FAILED");
    $fatal(1);
  end

  task automatic fillMemory();
    logic [`DATA_W-1:0] w;
    for (int i = 0; i < MEM_WORDS; i++) begin
      w = {$urandom, $urandom};
      u_memory.mem[i] = w;
      expMem[i] = w;
    end
  endtask

  // destination word i takes source word i * 2^shift
  function automatic void applyRule(input logic [31:0] src, input logic [31:0] dest,
                                    input int words, input int shift);
    int srcWord;
    int destWord;
    srcWord = int'(src >> 3);
    destWord = int'(dest >> 3);
    for (int i = 0; i < (words >> shift); i++) begin
      expMem[destWord + i] = expMem[srcWord + (i << shift)];
    end
  endfunction

  task automatic writeReg(input logic [`REG_IDX_W-1:0] idx, input logic [31:0] value);
    @(negedge FCLK0);
    regWrite.valid = 1'b1;
    regWrite.idx = idx;
    regWrite.value = value;
    @(negedge FCLK0);
    regWrite = '0;
  endtask

  task automatic launchJob(input logic [31:0] src, input logic [31:0] dest,
                           input int words, input int shift);
    lenWordT len;
    len.shift = 4'(shift);
    len.byteCount = 28'(words * 8);
    writeReg(`REG_SRC, src);
    writeReg(`REG_DEST, dest);
    writeReg(`REG_LEN, len);
    writeReg(`REG_CMD, 32'd1);
    applyRule(src, dest, words, shift);
  endtask

  task automatic waitIrq();
    do begin
      @(negedge FCLK0);
    end while (!irq);
  endtask

  // let the engine idle, then check irq count and the whole memory
  task automatic finishJobs(input int expIrqs);
    repeat (8) @(negedge FCLK0);
    checkBit(busy, 1'b0, "busy when idle");
    checkBit(irqCount == expIrqs, 1'b1,
             $sformatf("irq count %0d vs %0d equal", irqCount, expIrqs));
    for (int i = 0; i < MEM_WORDS; i++) begin
      checkWord(u_memory.mem[i], expMem[i], $sformatf("memory word %0d", i));
    end
  endtask

  task automatic checkIdleAfterReset();
    repeat (8) begin
      @(negedge FCLK0);
      checkBit(busy, 1'b0, "busy after reset");
      checkBit(irq, 1'b0, "irq after reset");
      checkBit(rdReqValid, 1'b0, "rdReqValid after reset");
      checkBit(wrReqValid, 1'b0, "wrReqValid after reset");
    end
  endtask

  task automatic testCopy();
    int base;
    base = irqCount;
    launchJob(32'h0000_0000, 32'h0000_1000, 32, 0);
    waitIrq();
    finishJobs(base + 1);
  endtask

  task automatic testDecimate();
    int base;
    base = irqCount;
    launchJob(32'h0000_0400, 32'h0000_1400, 64, 2);
    waitIrq();
    finishJobs(base + 1);
  endtask

  task automatic testStalls();
    int base;
    base = irqCount;
    @(negedge FCLK0);
    reqStall = 7'($urandom_range(60, 20));
    respStall = 7'($urandom_range(60, 20));
    wrStall = 7'($urandom_range(60, 20));
    launchJob(32'h0000_0800, 32'h0000_1800, 64, 0);
    waitIrq();
    finishJobs(base + 1);
    launchJob(32'h0000_0c00, 32'h0000_1a00, 64, 2);
    waitIrq();
    finishJobs(base + 2);
    @(negedge FCLK0);
    reqStall = '0;
    respStall = '0;
    wrStall = '0;
  endtask

  task automatic testStartWhileBusy();
    int base;
    base = irqCount;
    launchJob(32'h0000_0000, 32'h0000_1c00, 32, 0);
    checkBit(busy, 1'b1, "busy after start");
    writeReg(`REG_SRC, 32'h0000_0400);
    writeReg(`REG_CMD, 32'd1);
    checkBit(busy, 1'b1, "busy after ignored start");
    waitIrq();
    finishJobs(base + 1);
    // only the source changed since the first job
    writeReg(`REG_CMD, 32'd1);
    applyRule(32'h0000_0400, 32'h0000_1c00, 32, 0);
    waitIrq();
    finishJobs(base + 2);
  endtask

  task automatic testBackToBack();
    int base;
    lenWordT len;
    base = irqCount;
    launchJob(32'h0000_0800, 32'h0000_1000, 64, 1);
    len.shift = 4'd3;
    len.byteCount = 28'(64 * 8);
    writeReg(`REG_SRC, 32'h0000_0c00);
    writeReg(`REG_DEST, 32'h0000_1400);
    writeReg(`REG_LEN, len);
    waitIrq();
    writeReg(`REG_CMD, 32'd1);
    applyRule(32'h0000_0c00, 32'h0000_1400, 64, 3);
    waitIrq();
    finishJobs(base + 2);
  endtask

  initial begin
    void'($urandom(32'h9cb3_acb1));
    rstN = 1'b0;
    regWrite = '0;
    reqStall = '0;
    respStall = '0;
    wrStall = '0;
    fillMemory();
    repeat (4) @(posedge FCLK0);
    @(negedge FCLK0);
    rstN = 1'b1;
    checkIdleAfterReset();
    testCopy();
    testDecimate();
    testStalls();
    testStartWhileBusy();
    testBackToBack();
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
stagePkg.sv
dmaControl.sv
burstReader.sv
wordDecimator.sv
burstWriter.sv
streamStage.sv
tbMemoryModel.sv
tbStage.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbStage -f all.f -o simStage

# pass only if the simulation printed the pass line
./obj_dir/simStage 2>&1 | tee /dev/stderr | grep -qx "TEST OK"
echo "simulation passed"
